//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// The issue logic assumes exactly two instructions per issue group
`define ISSUE_NUM 2

`endif

//--- logic/mips_isa_pkg.sv
package mips_isa_pkg;

	typedef enum logic [5:0] {
		OPC_SPECIAL  = 6'b000000,
		OPC_BEQ      = 6'b000100,
		OPC_BNE      = 6'b000101,
		OPC_ADDIU    = 6'b001001,
		OPC_ORI      = 6'b001101,
		OPC_LUI      = 6'b001111,
		OPC_SPECIAL2 = 6'b011100, // Only the HI/LO check uses the MADD family
		OPC_LW       = 6'b100011,
		OPC_SW       = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		FN_MFHI = 6'b010000,
		FN_MTHI = 6'b010001,
		FN_MFLO = 6'b010010,
		FN_MTLO = 6'b010011,
		FN_MULT = 6'b011000,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010
	} funct_t;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_SLT,
		OP_ADDIU,
		OP_ORI,
		OP_LUI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_MULT,
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO
	} instr_op_t;

endpackage

//--- logic/cpu_types_pkg.sv
package cpu_types_pkg;

	typedef logic [31:0] uint32_t;

	localparam int FETCH_QUEUE_DEPTH = 8; // Also the sender's initial credit count
	localparam int QUEUE_PTR_W       = $clog2(FETCH_QUEUE_DEPTH);
	localparam int CREDIT_W          = 2; // Counts 0 to 2 per cycle

	typedef struct packed {
		logic    valid;
		uint32_t pc;
		uint32_t instr;
	} fetch_entry_t;

	typedef struct packed {
		mips_isa_pkg::instr_op_t op;
		logic [4:0]              rs1;
		logic [4:0]              rs2;
		logic [4:0]              rd;
		logic                    is_load;
		logic                    is_store;
	} decoded_instr_t;

endpackage

//--- logic/instr_fifo.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instr_fifo (
	input  logic                                               clk,
	input  logic                                               rst,
	input  logic                        [`ISSUE_NUM-1:0]       push_valid,
	input  cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]       push_pc,
	input  cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]       push_instr,
	input  logic                        [cpu_types_pkg::CREDIT_W-1:0] pop_num,
	output cpu_types_pkg::fetch_entry_t [`ISSUE_NUM-1:0]       fetch_entry,
	output logic                        [cpu_types_pkg::CREDIT_W-1:0] credit_return
);

	import cpu_types_pkg::*;

	uint32_t mem_pc    [FETCH_QUEUE_DEPTH];
	uint32_t mem_instr [FETCH_QUEUE_DEPTH];

	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W:0]   occupancy;
	logic [QUEUE_PTR_W:0]   push_cnt;
	logic [QUEUE_PTR_W:0]   pop_cnt;

	// Slot 1 is only ever pushed together with slot 0
	assign push_cnt = (QUEUE_PTR_W+1)'(push_valid[0]) + (QUEUE_PTR_W+1)'(push_valid[1]);
	assign pop_cnt  = (QUEUE_PTR_W+1)'(pop_num);

	always_ff @(posedge clk) begin
		if (push_valid[0]) begin
			mem_pc[wr_ptr]    <= push_pc[0];
			mem_instr[wr_ptr] <= push_instr[0];
		end
		if (push_valid[1]) begin
			mem_pc[wr_ptr + QUEUE_PTR_W'(1)]    <= push_pc[1];
			mem_instr[wr_ptr + QUEUE_PTR_W'(1)] <= push_instr[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr        <= '0;
			wr_ptr        <= '0;
			occupancy     <= '0;
			credit_return <= '0;
		end else begin
			wr_ptr        <= wr_ptr + QUEUE_PTR_W'(push_cnt);
			rd_ptr        <= rd_ptr + QUEUE_PTR_W'(pop_num);
			occupancy     <= occupancy + push_cnt - pop_cnt; // Credits keep this within depth
			credit_return <= pop_num; // Every popped entry frees one credit
		end
	end

	// The head entries are read straight from the buffer
	for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_head
		assign fetch_entry[i].valid = occupancy > (QUEUE_PTR_W+1)'(i);
		assign fetch_entry[i].pc    = mem_pc[rd_ptr + QUEUE_PTR_W'(i)];
		assign fetch_entry[i].instr = mem_instr[rd_ptr + QUEUE_PTR_W'(i)];
	end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  cpu_types_pkg::uint32_t        instr,
	output cpu_types_pkg::decoded_instr_t decoded
);

	import mips_isa_pkg::*;

	opcode_t    opcode;
	funct_t     funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct  = funct_t'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	always_comb begin
		decoded    = '0;
		decoded.op = OP_NOP; // Unknown words fall through as NOP with zero fields
		case (opcode)
			OPC_SPECIAL: begin
				case (funct)
					FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT: begin
						decoded.rs1 = rs;
						decoded.rs2 = rt;
						decoded.rd  = rd;
						case (funct)
							FN_ADDU: decoded.op = OP_ADDU;
							FN_SUBU: decoded.op = OP_SUBU;
							FN_AND:  decoded.op = OP_AND;
							FN_OR:   decoded.op = OP_OR;
							default: decoded.op = OP_SLT;
						endcase
					end
					FN_MULT: begin
						decoded.op  = OP_MULT;
						decoded.rs1 = rs;
						decoded.rs2 = rt;
					end
					FN_MTHI, FN_MTLO: begin
						decoded.op  = (funct == FN_MTHI) ? OP_MTHI : OP_MTLO;
						decoded.rs1 = rs;
					end
					FN_MFHI, FN_MFLO: begin
						decoded.op = (funct == FN_MFHI) ? OP_MFHI : OP_MFLO;
						decoded.rd = rd;
					end
					default: ;
				endcase
			end
			OPC_ADDIU, OPC_ORI: begin
				decoded.op  = (opcode == OPC_ADDIU) ? OP_ADDIU : OP_ORI;
				decoded.rs1 = rs;
				decoded.rd  = rt; // I-type writes rt
			end
			OPC_LUI: begin
				decoded.op = OP_LUI;
				decoded.rd = rt;
			end
			OPC_LW: begin
				decoded.op      = OP_LW;
				decoded.rs1     = rs;
				decoded.rd      = rt;
				decoded.is_load = 1'b1;
			end
			OPC_SW, OPC_BEQ, OPC_BNE: begin
				decoded.rs1      = rs;
				decoded.rs2      = rt;
				decoded.is_store = (opcode == OPC_SW);
				case (opcode)
					OPC_SW:  decoded.op = OP_SW;
					OPC_BEQ: decoded.op = OP_BEQ;
					default: decoded.op = OP_BNE;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- logic/instr_issue.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instr_issue (
	input  cpu_types_pkg::fetch_entry_t   [`ISSUE_NUM-1:0] fetch_entry,
	input  cpu_types_pkg::decoded_instr_t [`ISSUE_NUM-1:0] id_decoded,
	input  cpu_types_pkg::decoded_instr_t [`ISSUE_NUM-1:0] ex_decoded,
	input  logic                                           delayslot_not_exec,
	output cpu_types_pkg::decoded_instr_t [`ISSUE_NUM-1:0] issue_instr,
	output logic [$clog2(`ISSUE_NUM+1)-1:0]                issue_num,
	output logic                                           stall_req
);

	import mips_isa_pkg::*;
	import cpu_types_pkg::*;

	logic                  slot1_held;
	logic [`ISSUE_NUM-1:0] head_valid;
	logic [`ISSUE_NUM-1:0] load_use;
	logic [`ISSUE_NUM-1:0] mem_access;
	logic [`ISSUE_NUM-1:0] hilo_access;

	// Any instruction that touches HI or LO as seen in its raw encoding
	function automatic logic uses_hilo(input uint32_t instr);
		logic special;
		logic special2;
		special  = instr[31:26] == OPC_SPECIAL;
		special2 = instr[31:26] == OPC_SPECIAL2;
		return (special && instr[5:4] == 2'b01 && !instr[2])
			|| (special2 && instr[5:3] == 3'b000 && !instr[1]);
	endfunction

	function automatic logic reads_reg(input decoded_instr_t rdr, input logic [4:0] r);
		return r != '0 && (rdr.rs1 == r || rdr.rs2 == r);
	endfunction

	for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_slot
		assign head_valid[i]  = fetch_entry[i].valid;
		assign mem_access[i]  = id_decoded[i].is_load | id_decoded[i].is_store;
		assign hilo_access[i] = uses_hilo(fetch_entry[i].instr);
	end

	always_comb begin
		load_use = '0;
		for (int i = 0; i < `ISSUE_NUM; ++i) begin
			for (int j = 0; j < `ISSUE_NUM; ++j) begin
				load_use[i] |= ex_decoded[j].is_load & reads_reg(id_decoded[i], ex_decoded[j].rd);
			end
		end
		load_use &= head_valid; // Stale head data must not stall
	end

	assign slot1_held = ~head_valid[1]
		| reads_reg(id_decoded[1], id_decoded[0].rd)
		| (mem_access[0] & mem_access[1])
		| (hilo_access[0] & hilo_access[1])
		| delayslot_not_exec; // Mispredicted branch with a squashed delay slot

	assign stall_req = (|load_use) | (head_valid == '0);

	always_comb begin
		issue_instr = id_decoded;
		issue_num   = 2'd2;
		if (slot1_held) begin
			issue_instr[1] = '0;
			issue_num      = 2'd1;
		end
	end

endmodule

//--- logic/issue_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module issue_unit (
	input  logic                                            clk,
	input  logic                                            rst,
	input  cpu_types_pkg::fetch_entry_t [`ISSUE_NUM-1:0]    fetch_entry,
	input  logic                                            delayslot_not_exec,
	output logic                    [cpu_types_pkg::CREDIT_W-1:0] pop_num,
	output logic                        [`ISSUE_NUM-1:0]    ex_valid,
	output cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]    ex_pc,
	output cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]    ex_instr,
	output mips_isa_pkg::instr_op_t     [`ISSUE_NUM-1:0]    ex_op,
	output logic                    [cpu_types_pkg::CREDIT_W-1:0] ex_num
);

	import cpu_types_pkg::*;

	decoded_instr_t [`ISSUE_NUM-1:0] id_decoded;
	decoded_instr_t [`ISSUE_NUM-1:0] ex_decoded;
	decoded_instr_t [`ISSUE_NUM-1:0] issue_instr;
	logic [CREDIT_W-1:0]             issue_num;
	logic                            stall_req;

	for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_dec
		instr_decoder i_decoder (
			.instr   (fetch_entry[i].instr),
			.decoded (id_decoded[i])
		);
		assign ex_op[i] = ex_decoded[i].op;
	end

	instr_issue i_issue (
		.fetch_entry        (fetch_entry),
		.id_decoded         (id_decoded),
		.ex_decoded         (ex_decoded),
		.delayslot_not_exec (delayslot_not_exec),
		.issue_instr        (issue_instr),
		.issue_num          (issue_num),
		.stall_req          (stall_req)
	);

	assign pop_num = stall_req ? '0 : issue_num;
	assign ex_num  = CREDIT_W'(ex_valid[0]) + CREDIT_W'(ex_valid[1]);

	// Decoded half of ID/EX also drives the load-use check
	always_ff @(posedge clk) begin
		if (rst || stall_req) begin
			ex_valid   <= '0; // Bubble
			ex_decoded <= '0;
		end else begin
			ex_valid   <= {issue_num == 2'd2, 1'b1};
			ex_decoded <= issue_instr; // Held slot 1 is already cleared
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `ISSUE_NUM; ++i) begin
			ex_pc[i]    <= fetch_entry[i].pc;
			ex_instr[i] <= fetch_entry[i].instr;
		end
	end

endmodule

//--- logic/issue_stage_top.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module issue_stage_top (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic                        [`ISSUE_NUM-1:0]    fetch_valid,
	input  cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]    fetch_pc,
	input  cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]    fetch_instr,
	output logic                    [cpu_types_pkg::CREDIT_W-1:0] credit_return,
	input  logic                                            delayslot_not_exec,
	output logic                        [`ISSUE_NUM-1:0]    ex_valid,
	output cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]    ex_pc,
	output cpu_types_pkg::uint32_t      [`ISSUE_NUM-1:0]    ex_instr,
	output mips_isa_pkg::instr_op_t     [`ISSUE_NUM-1:0]    ex_op,
	output logic                    [cpu_types_pkg::CREDIT_W-1:0] ex_num
);

	import cpu_types_pkg::*;

	fetch_entry_t [`ISSUE_NUM-1:0] fetch_entry;
	logic [CREDIT_W-1:0]           pop_num;

	instr_fifo i_fifo (
		.clk           (clk),
		.rst           (rst),
		.push_valid    (fetch_valid),
		.push_pc       (fetch_pc),
		.push_instr    (fetch_instr),
		.pop_num       (pop_num),
		.fetch_entry   (fetch_entry),
		.credit_return (credit_return)
	);

	issue_unit i_issue_unit (
		.clk                (clk),
		.rst                (rst),
		.fetch_entry        (fetch_entry),
		.delayslot_not_exec (delayslot_not_exec),
		.pop_num            (pop_num),
		.ex_valid           (ex_valid),
		.ex_pc              (ex_pc),
		.ex_instr           (ex_instr),
		.ex_op              (ex_op),
		.ex_num             (ex_num)
	);

endmodule

//--- tb/issue_stage_assertions.sv
`timescale 1ns/1ps

module issue_stage_assertions #(
	parameter bit FIFO_SIDE = 1'b1
) (
	input logic                                   clk,
	input logic                                   rst,
	input logic [cpu_types_pkg::QUEUE_PTR_W:0]    occupancy,
	input logic [cpu_types_pkg::CREDIT_W-1:0]     credit_return,
	input logic [1:0]                             ex_valid,
	input logic                                   stall_req,
	input logic [cpu_types_pkg::CREDIT_W-1:0]     pop_num
);

	import cpu_types_pkg::*;

	if (FIFO_SIDE) begin : gen_fifo_checks
		occupancy_bound: assert property (@(posedge clk) disable iff (rst)
			occupancy <= (QUEUE_PTR_W+1)'(FETCH_QUEUE_DEPTH))
			else $error("queue occupancy above depth");
		credit_bound: assert property (@(posedge clk) disable iff (rst)
			credit_return <= CREDIT_W'(2))
			else $error("credit_return above two");
	end else begin : gen_issue_checks
		slot_order: assert property (@(posedge clk) disable iff (rst)
			ex_valid[1] |-> ex_valid[0])
			else $error("ex slot 1 valid without slot 0");
		stall_no_pop: assert property (@(posedge clk) disable iff (rst)
			stall_req |-> pop_num == '0)
			else $error("pop during stall");
	end

endmodule

bind instr_fifo issue_stage_assertions #(.FIFO_SIDE(1'b1)) i_fifo_assertions (
	.clk(clk), .rst(rst), .occupancy(occupancy), .credit_return(credit_return),
	.ex_valid(2'b00), .stall_req(1'b0), .pop_num(2'b00)
);

bind issue_unit issue_stage_assertions #(.FIFO_SIDE(1'b0)) i_issue_assertions (
	.clk(clk), .rst(rst), .occupancy('0), .credit_return(2'b00),
	.ex_valid(ex_valid), .stall_req(stall_req), .pop_num(pop_num)
);

//--- tb/tb_issue_stage.sv
`timescale 1ns/1ps

module tb_issue_stage;

	import mips_isa_pkg::*;
	import cpu_types_pkg::*;

	localparam int NUM_INSTR  = 400;
	localparam int CLK_PERIOD = 20;

	typedef struct packed {
		instr_op_t  op;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic       is_load;
		logic       is_mem;
		logic       hilo;
	} model_dec_t;

	logic                  clk;
	logic                  rst;
	logic [1:0]            fetch_valid;
	logic [1:0][31:0]      fetch_pc;
	logic [1:0][31:0]      fetch_instr;
	logic [CREDIT_W-1:0]   credit_return;
	logic                  delayslot_not_exec;
	logic [1:0]            ex_valid;
	logic [1:0][31:0]      ex_pc;
	logic [1:0][31:0]      ex_instr;
	instr_op_t [1:0]       ex_op;
	logic [CREDIT_W-1:0]   ex_num;

	integer          seed = 32'h44c4;
	logic [31:0]     q_pc[$];
	logic [31:0]     q_instr[$];
	model_dec_t      ex_dec[2];
	logic [1:0]      exp_valid;
	logic [1:0][31:0] exp_pc;
	logic [1:0][31:0] exp_instr;
	model_dec_t      exp_dec[2];
	int              exp_credit;
	int              credits;
	int              generated;
	int              exits;
	int              credit_sum;

	issue_stage_top i_dut (
		.clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
		.fetch_instr(fetch_instr), .credit_return(credit_return),
		.delayslot_not_exec(delayslot_not_exec), .ex_valid(ex_valid), .ex_pc(ex_pc),
		.ex_instr(ex_instr), .ex_op(ex_op), .ex_num(ex_num)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * (20 * NUM_INSTR + 8));
		$display("Watchdog expired before all instructions left through EX");
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	// Decode straight from the MIPS32 encodings
	function automatic model_dec_t decode_model(input logic [31:0] w);
		model_dec_t d;
		d = '0;
		d.op = OP_NOP;
		case (w[31:26])
			6'h00: begin
				case (w[5:0])
					6'h21: d.op = OP_ADDU;
					6'h23: d.op = OP_SUBU;
					6'h24: d.op = OP_AND;
					6'h25: d.op = OP_OR;
					6'h2a: d.op = OP_SLT;
					6'h18: d.op = OP_MULT;
					6'h10: d.op = OP_MFHI;
					6'h12: d.op = OP_MFLO;
					6'h11: d.op = OP_MTHI;
					6'h13: d.op = OP_MTLO;
					default: ;
				endcase
				if (d.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT, OP_MULT, OP_MTHI, OP_MTLO})
					d.rs1 = w[25:21];
				if (d.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT, OP_MULT})
					d.rs2 = w[20:16];
				if (d.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT, OP_MFHI, OP_MFLO})
					d.rd = w[15:11];
				d.hilo = d.op inside {OP_MULT, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO};
			end
			6'h09, 6'h0d, 6'h23: begin
				d.op = (w[31:26] == 6'h09) ? OP_ADDIU : (w[31:26] == 6'h0d) ? OP_ORI : OP_LW;
				d.rs1 = w[25:21];
				d.rd = w[20:16];
				d.is_load = (w[31:26] == 6'h23);
				d.is_mem = d.is_load;
			end
			6'h0f: begin
				d.op = OP_LUI;
				d.rd = w[20:16];
			end
			6'h2b, 6'h04, 6'h05: begin
				d.op = (w[31:26] == 6'h2b) ? OP_SW : (w[31:26] == 6'h04) ? OP_BEQ : OP_BNE;
				d.rs1 = w[25:21];
				d.rs2 = w[20:16];
				d.is_mem = (w[31:26] == 6'h2b);
			end
			default: ;
		endcase
		return d;
	endfunction

	function automatic logic reads_reg(input model_dec_t d, input logic [4:0] r);
		return r != 5'd0 && (d.rs1 == r || d.rs2 == r);
	endfunction

	// Registers come from r0 to r3 so that hazards come up often
	function automatic logic [31:0] gen_instr();
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		int          k;
		logic [5:0]  fn[10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h2a, 6'h18, 6'h10, 6'h12, 6'h11, 6'h13};
		logic [5:0]  opc[7] = '{6'h09, 6'h0d, 6'h0f, 6'h23, 6'h2b, 6'h04, 6'h05};
		rs = 5'($unsigned($random(seed)) % 4);
		rt = 5'($unsigned($random(seed)) % 4);
		rd = 5'($unsigned($random(seed)) % 4);
		imm = 16'($random(seed));
		k = $unsigned($random(seed)) % 18;
		if (k == 17)
			return 32'h0;
		if (k < 10)
			return {6'h00, rs, rt, rd, 5'd0, fn[k]};
		return {opc[k-10], rs, rt, imm};
	endfunction

	task automatic drive_and_predict();
		int         n_push;
		model_dec_t d0;
		model_dec_t d1;
		logic       v0;
		logic       v1;
		logic       stall;
		logic       held;
		n_push = 0;
		if (generated < NUM_INSTR) begin
			n_push = $unsigned($random(seed)) % 3;
			if (n_push > credits)
				n_push = credits;
			if (n_push > NUM_INSTR - generated)
				n_push = NUM_INSTR - generated;
		end
		fetch_valid = '0;
		for (int k = 0; k < n_push; k++) begin
			fetch_valid[k] = 1'b1;
			fetch_pc[k] = 32'h0040_0000 + 32'(4 * generated);
			fetch_instr[k] = gen_instr();
			generated++;
		end
		delayslot_not_exec = ($random(seed) & 7) == 0; // About one cycle in eight
		v0 = q_pc.size() > 0;
		v1 = q_pc.size() > 1;
		d0 = v0 ? decode_model(q_instr[0]) : '0;
		d1 = v1 ? decode_model(q_instr[1]) : '0;
		stall = !v0;
		for (int j = 0; j < 2; j++) begin
			if (ex_dec[j].is_load && ((v0 && reads_reg(d0, ex_dec[j].rd))
				|| (v1 && reads_reg(d1, ex_dec[j].rd))))
				stall = 1'b1;
		end
		held = !v1 || reads_reg(d1, d0.rd) || (d0.is_mem && d1.is_mem)
			|| (d0.hilo && d1.hilo) || delayslot_not_exec;
		if (stall) begin
			exp_valid = 2'b00; // Bubble
			exp_credit = 0;
			ex_dec[0] = '0;
			ex_dec[1] = '0;
		end else begin
			exp_valid = {!held, 1'b1};
			exp_credit = held ? 1 : 2;
			ex_dec[0] = d0;
			ex_dec[1] = held ? model_dec_t'('0) : d1;
			for (int k = 0; k < exp_credit; k++) begin
				exp_pc[k] = q_pc.pop_front();
				exp_instr[k] = q_instr.pop_front();
				exp_dec[k] = ex_dec[k];
			end
		end
		for (int k = 0; k < n_push; k++) begin
			q_pc.push_back(fetch_pc[k]);
			q_instr.push_back(fetch_instr[k]);
		end
		credits -= n_push;
	endtask

	initial begin
		rst = 1'b1;
		fetch_valid = '0;
		fetch_pc = '0;
		fetch_instr = '0;
		delayslot_not_exec = 1'b0;
		ex_dec[0] = '0;
		ex_dec[1] = '0;
		credits = FETCH_QUEUE_DEPTH;
		generated = 0;
		exits = 0;
		credit_sum = 0;
		repeat (8) begin
			@(posedge clk);
			#1;
			check_value("reset ex_valid", 32'd0, 32'(ex_valid));
			check_value("reset credit_return", 32'd0, 32'(credit_return));
		end
		rst = 1'b0;
		drive_and_predict();
		while (exits < NUM_INSTR) begin
			@(posedge clk);
			#1;
			check_value("ex_valid", 32'(exp_valid), 32'(ex_valid));
			check_value("ex_num", 32'(exp_credit), 32'(ex_num));
			check_value("credit_return", 32'(exp_credit), 32'(credit_return));
			for (int k = 0; k < 2; k++) begin
				if (exp_valid[k]) begin
					check_value("ex_pc", exp_pc[k], ex_pc[k]);
					check_value("ex_instr", exp_instr[k], ex_instr[k]);
					check_value("ex_op", 32'(exp_dec[k].op), 32'(ex_op[k]));
					exits++;
				end
			end
			credits += credit_return; // Returned credits go back to the sender
			credit_sum += credit_return;
			drive_and_predict();
		end
		check_value("credit sum", 32'(NUM_INSTR), 32'(credit_sum));
		check_value("final credits", 32'(FETCH_QUEUE_DEPTH), 32'(credits));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- files.f
+incdir+include
logic/mips_isa_pkg.sv
logic/cpu_types_pkg.sv
logic/instr_fifo.sv
logic/instr_decoder.sv
logic/instr_issue.sv
logic/issue_unit.sv
logic/issue_stage_top.sv
tb/issue_stage_assertions.sv
tb/tb_issue_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_issue_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' files.f) include/cpu_defs.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
